// ==== source/radio_regs_pkg.sv ====
//////////////////////////////
// Settings and readback register map, RX command opcodes
// and error counter width
//////////////////////////////

package radio_regs_pkg;

  // Settings bus addresses
  typedef enum logic [7:0] {
    SR_TIME_HI   = 8'd128,
    SR_TIME_LO   = 8'd129,
    SR_TIME_CTRL = 8'd130,
    SR_RX_CMD    = 8'd132
  } set_addr_e;

  // SR_TIME_CTRL bits
  localparam int TIME_CTRL_NOW_BIT = 0;
  localparam int TIME_CTRL_PPS_BIT = 1;

  // SR_RX_CMD fields
  localparam int RX_CMD_OP_LSB = 30;
  localparam int RX_CMD_CNT_W  = 24;

  // Also used as the RX command FSM states
  typedef enum logic [1:0] {
    RX_STOP      = 2'd0,
    RX_CONT      = 2'd1,
    RX_NUM_SAMPS = 2'd2
  } rx_cmd_e;

  typedef enum logic [7:0] {
    RB_VITA_TIME     = 8'd0,
    RB_VITA_LASTPPS  = 8'd1,
    RB_RX_OVERFLOWS  = 8'd2,
    RB_TX_UNDERFLOWS = 8'd3,
    RB_TX_LATE       = 8'd4
  } rb_addr_e;

  localparam int CNT_W = 32;

endpackage

// ==== source/chdr_pkg.sv ====
//////////////////////////////
// Packet header layout, packet types and TX deframer states
//////////////////////////////

package chdr_pkg;

  // Header word fields, low 32 bits are zero
  localparam int HDR_TYPE_LSB     = 62;
  localparam int HDR_TYPE_W       = 2;
  localparam int HDR_HAS_TIME_BIT = 61;
  localparam int HDR_EOB_BIT      = 60;
  localparam int HDR_SEQ_LSB      = 48;
  localparam int HDR_SEQ_W        = 12;
  localparam int HDR_LEN_LSB      = 32;
  localparam int HDR_LEN_W        = 16;

  typedef enum logic [1:0] {
    PKT_DATA = 2'd0,
    PKT_CMD  = 2'd2,
    PKT_RESP = 2'd3
  } pkt_type_e;

  typedef enum logic [1:0] {
    TX_HDR,
    TX_TIME,
    TX_WAIT,
    TX_PLAY
  } tx_state_e;

endpackage

// ==== source/radio_ctrl.sv ====
//////////////////////////////
// Settings decode, time load staging, RX command FSM,
// error counters and readback mux
//////////////////////////////

module radio_ctrl (
  input  logic        ce_clk,
  input  logic        i_rst,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic        i_rb_stb,
  input  logic [7:0]  i_rb_addr,
  output logic        o_rb_stb,
  output logic [63:0] o_rb_data,
  input  logic [63:0] i_vita_time,
  input  logic [63:0] i_vita_lastpps,
  input  logic        i_rx_stb,
  output logic        o_rx_enable,
  output logic        o_rx_last,
  input  logic        i_rx_overflow,
  input  logic        i_tx_underflow,
  input  logic        i_tx_late,
  output logic [63:0] o_time_value,
  output logic        o_load_now,
  output logic        o_load_pps
);

  logic wr_hi, wr_lo, wr_ctrl, wr_rx;
  logic [31:0] time_hi;
  logic [radio_regs_pkg::RX_CMD_CNT_W-1:0] rx_remaining;
  radio_regs_pkg::rx_cmd_e rx_state;
  logic [radio_regs_pkg::CNT_W-1:0] rx_overflows, tx_underflows, tx_late_cnt;

  always_comb begin
    wr_hi   = 1'b0;
    wr_lo   = 1'b0;
    wr_ctrl = 1'b0;
    wr_rx   = 1'b0;
    case (radio_regs_pkg::set_addr_e'(i_set_addr))
      radio_regs_pkg::SR_TIME_HI:   wr_hi   = i_set_stb;
      radio_regs_pkg::SR_TIME_LO:   wr_lo   = i_set_stb;
      radio_regs_pkg::SR_TIME_CTRL: wr_ctrl = i_set_stb;
      radio_regs_pkg::SR_RX_CMD:    wr_rx   = i_set_stb;
      default: ;
    endcase
  end

  //////////////////////////////
  // Time load staging
  //////////////////////////////
  // LO write completes the 64-bit value
  always_ff @(posedge ce_clk) begin
    if (wr_hi) time_hi <= i_set_data;
    if (wr_lo) o_time_value <= {time_hi, i_set_data};
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_load_now <= 1'b0;
      o_load_pps <= 1'b0;
    end else begin
      o_load_now <= wr_ctrl && i_set_data[radio_regs_pkg::TIME_CTRL_NOW_BIT];
      o_load_pps <= wr_ctrl && i_set_data[radio_regs_pkg::TIME_CTRL_PPS_BIT];
    end
  end

  //////////////////////////////
  // RX command FSM
  //////////////////////////////
  assign o_rx_enable = (rx_state != radio_regs_pkg::RX_STOP);
  assign o_rx_last = (rx_state == radio_regs_pkg::RX_NUM_SAMPS) && i_rx_stb
                     && (rx_remaining == radio_regs_pkg::RX_CMD_CNT_W'(1));

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      rx_state     <= radio_regs_pkg::RX_STOP;
      rx_remaining <= '0;
    end else if (wr_rx) begin
      rx_remaining <= i_set_data[radio_regs_pkg::RX_CMD_CNT_W-1:0];
      case (radio_regs_pkg::rx_cmd_e'(i_set_data[radio_regs_pkg::RX_CMD_OP_LSB +: 2]))
        radio_regs_pkg::RX_CONT: rx_state <= radio_regs_pkg::RX_CONT;
        // A zero-length burst is ignored
        radio_regs_pkg::RX_NUM_SAMPS:
          rx_state <= (i_set_data[radio_regs_pkg::RX_CMD_CNT_W-1:0] == '0) ?
                      radio_regs_pkg::RX_STOP : radio_regs_pkg::RX_NUM_SAMPS;
        default: rx_state <= radio_regs_pkg::RX_STOP;
      endcase
    end else if (rx_state == radio_regs_pkg::RX_NUM_SAMPS && i_rx_stb) begin
      rx_remaining <= rx_remaining - 1'b1;
      if (o_rx_last) rx_state <= radio_regs_pkg::RX_STOP;
    end
  end

  //////////////////////////////
  // Error counters and readback
  //////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      rx_overflows  <= '0;
      tx_underflows <= '0;
      tx_late_cnt   <= '0;
    end else begin
      if (i_rx_overflow) rx_overflows <= rx_overflows + 1'b1;
      if (i_tx_underflow) tx_underflows <= tx_underflows + 1'b1;
      if (i_tx_late) tx_late_cnt <= tx_late_cnt + 1'b1;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) o_rb_stb <= 1'b0;
    else o_rb_stb <= i_rb_stb;
  end

  always_ff @(posedge ce_clk) begin
    case (radio_regs_pkg::rb_addr_e'(i_rb_addr))
      radio_regs_pkg::RB_VITA_TIME:     o_rb_data <= i_vita_time;
      radio_regs_pkg::RB_VITA_LASTPPS:  o_rb_data <= i_vita_lastpps;
      radio_regs_pkg::RB_RX_OVERFLOWS:  o_rb_data <= 64'(rx_overflows);
      radio_regs_pkg::RB_TX_UNDERFLOWS: o_rb_data <= 64'(tx_underflows);
      radio_regs_pkg::RB_TX_LATE:       o_rb_data <= 64'(tx_late_cnt);
      default:                          o_rb_data <= '0;
    endcase
  end

endmodule

// ==== source/timekeeper.sv ====
//////////////////////////////
// 64-bit radio time with immediate and PPS-synchronous load
//////////////////////////////

module timekeeper (
  input  logic        ce_clk,
  input  logic        i_rst,
  input  logic        i_pps,
  input  logic        i_rx_stb,
  input  logic [63:0] i_time_value,
  input  logic        i_load_now,
  input  logic        i_load_pps,
  output logic [63:0] o_vita_time,
  output logic [63:0] o_vita_lastpps
);

  logic pps_d;
  logic pps_rise;
  logic armed;
  logic [63:0] time_next;

  assign pps_rise = i_pps && !pps_d;

  // Load-now wins over the sample strobe
  always_comb begin
    time_next = o_vita_time;
    if (i_load_now || (pps_rise && armed)) time_next = i_time_value;
    else if (i_rx_stb) time_next = o_vita_time + 64'd1;
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      pps_d          <= 1'b0;
      armed          <= 1'b0;
      o_vita_time    <= '0;
      o_vita_lastpps <= '0;
    end else begin
      pps_d       <= i_pps;
      o_vita_time <= time_next;
      if (pps_rise) begin
        o_vita_lastpps <= time_next;
        armed          <= 1'b0;
      end
      // Arming on the edge cycle waits for the next edge
      if (i_load_pps) armed <= 1'b1;
    end
  end

endmodule

// ==== source/rx_framer.sv ====
//////////////////////////////
// RX sample packer with two ping-pong packet buffers
//////////////////////////////

module rx_framer #(
  parameter int SPP = 8
) (
  input  logic        ce_clk,
  input  logic        i_rst,
  input  logic [31:0] i_rx_sample,
  input  logic        i_rx_stb,
  input  logic        i_rx_enable,
  input  logic        i_rx_last,
  input  logic [63:0] i_vita_time,
  output logic [63:0] o_rx_tdata,
  output logic        o_rx_tlast,
  output logic        o_rx_tvalid,
  input  logic        i_rx_tready,
  output logic        o_rx_overflow
);

  localparam int CW = $clog2(SPP + 1);
  localparam int SW = $clog2(SPP);
  localparam int WW = $clog2(SPP / 2 + 3);

  logic [31:0] buf_mem [2][SPP];
  logic [63:0] buf_time [2];
  logic [CW-1:0] buf_cnt [2];
  logic [1:0] buf_eob, buf_full;
  logic fill_sel, send_sel;
  logic [CW-1:0] fill_cnt;
  logic accept, closing, xfer;
  logic [WW-1:0] word_idx, last_word;
  logic [SW-1:0] samp_idx;
  logic [chdr_pkg::HDR_SEQ_W-1:0] seq_num;
  logic [chdr_pkg::HDR_LEN_W-1:0] pkt_len;
  logic [63:0] hdr_word;

  // Fill side
  assign accept  = i_rx_stb && i_rx_enable && !buf_full[fill_sel];
  assign closing = accept && (fill_cnt == CW'(SPP - 1) || i_rx_last);

  always_ff @(posedge ce_clk) begin
    if (accept) begin
      buf_mem[fill_sel][fill_cnt[SW-1:0]] <= i_rx_sample;
      if (fill_cnt == '0) buf_time[fill_sel] <= i_vita_time;
    end
    if (closing) begin
      buf_cnt[fill_sel] <= fill_cnt + 1'b1;
      buf_eob[fill_sel] <= i_rx_last;
    end
  end

  //////////////////////////////
  // Send side
  //////////////////////////////
  assign o_rx_tvalid = buf_full[send_sel];
  assign o_rx_tlast  = (word_idx == last_word);
  assign xfer        = o_rx_tvalid && i_rx_tready;

  always_comb begin
    // Header, time word, then two samples per word
    pkt_len   = chdr_pkg::HDR_LEN_W'((2 + (buf_cnt[send_sel] + 1) / 2) * 8);
    last_word = WW'(1 + (buf_cnt[send_sel] + 1) / 2);
    samp_idx  = SW'((word_idx - 2) * 2);

    hdr_word = '0;
    hdr_word[chdr_pkg::HDR_TYPE_LSB +: chdr_pkg::HDR_TYPE_W] = chdr_pkg::PKT_DATA;
    hdr_word[chdr_pkg::HDR_HAS_TIME_BIT] = 1'b1;
    hdr_word[chdr_pkg::HDR_EOB_BIT] = buf_eob[send_sel];
    hdr_word[chdr_pkg::HDR_SEQ_LSB +: chdr_pkg::HDR_SEQ_W] = seq_num;
    hdr_word[chdr_pkg::HDR_LEN_LSB +: chdr_pkg::HDR_LEN_W] = pkt_len;

    if (word_idx == '0) begin
      o_rx_tdata = hdr_word;
    end else if (word_idx == WW'(1)) begin
      o_rx_tdata = buf_time[send_sel];
    end else begin
      o_rx_tdata[63:32] = buf_mem[send_sel][samp_idx];
      // Odd final sample leaves the low half empty
      o_rx_tdata[31:0] = (samp_idx + 1 < buf_cnt[send_sel]) ?
                         buf_mem[send_sel][SW'(samp_idx + 1)] : '0;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      buf_full      <= '0;
      fill_sel      <= 1'b0;
      send_sel      <= 1'b0;
      fill_cnt      <= '0;
      word_idx      <= '0;
      seq_num       <= '0;
      o_rx_overflow <= 1'b0;
    end else begin
      o_rx_overflow <= i_rx_stb && i_rx_enable && buf_full[fill_sel];
      if (closing) begin
        buf_full[fill_sel] <= 1'b1;
        fill_sel <= ~fill_sel;
        fill_cnt <= '0;
      end else if (accept) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      if (xfer && o_rx_tlast) begin
        buf_full[send_sel] <= 1'b0;
        send_sel <= ~send_sel;
        word_idx <= '0;
        seq_num  <= seq_num + 1'b1;
      end else if (xfer) begin
        word_idx <= word_idx + 1'b1;
      end
    end
  end

endmodule

// ==== source/tx_deframer.sv ====
//////////////////////////////
// TX packet parser with timed start and strobed sample playout
//////////////////////////////

module tx_deframer (
  input  logic        ce_clk,
  input  logic        i_rst,
  input  logic [63:0] i_tx_tdata,
  input  logic        i_tx_tlast,
  input  logic        i_tx_tvalid,
  output logic        o_tx_tready,
  input  logic        i_tx_stb,
  input  logic [63:0] i_vita_time,
  output logic [31:0] o_tx_sample,
  output logic        o_tx_underflow,
  output logic        o_tx_late
);

  chdr_pkg::tx_state_e state;
  logic [63:0] hold_data;
  logic hold_valid, hold_last, hold_valid_next;
  logic [63:0] pkt_time;
  logic pkt_eob;
  logic half_sel;
  logic burst_open;
  logic play_now, consume;

  // One-word holding stage, ready only while it is empty
  always_comb begin
    play_now = i_tx_stb && hold_valid &&
               (state == chdr_pkg::TX_PLAY ||
                (state == chdr_pkg::TX_WAIT && i_vita_time >= pkt_time));
    case (state)
      chdr_pkg::TX_HDR, chdr_pkg::TX_TIME: consume = hold_valid;
      default: consume = play_now && half_sel;
    endcase
    hold_valid_next = (hold_valid && !consume) || (o_tx_tready && i_tx_tvalid);
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      hold_valid  <= 1'b0;
      o_tx_tready <= 1'b0;
    end else begin
      hold_valid  <= hold_valid_next;
      o_tx_tready <= !hold_valid_next;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (o_tx_tready && i_tx_tvalid) begin
      hold_data <= i_tx_tdata;
      hold_last <= i_tx_tlast;
    end
  end

  //////////////////////////////
  // Packet FSM and playout
  //////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state          <= chdr_pkg::TX_HDR;
      pkt_eob        <= 1'b0;
      half_sel       <= 1'b0;
      burst_open     <= 1'b0;
      o_tx_sample    <= '0;
      o_tx_underflow <= 1'b0;
      o_tx_late      <= 1'b0;
    end else begin
      o_tx_underflow <= 1'b0;
      o_tx_late      <= 1'b0;
      // Strobe with nothing to play
      if (i_tx_stb && !play_now) begin
        o_tx_sample    <= '0;
        o_tx_underflow <= burst_open;
      end
      case (state)
        chdr_pkg::TX_HDR: begin
          if (hold_valid) begin
            pkt_eob  <= hold_data[chdr_pkg::HDR_EOB_BIT];
            half_sel <= 1'b0;
            if (!hold_last)
              state <= hold_data[chdr_pkg::HDR_HAS_TIME_BIT] ?
                       chdr_pkg::TX_TIME : chdr_pkg::TX_PLAY;
          end
        end
        chdr_pkg::TX_TIME: begin
          if (hold_valid) begin
            pkt_time <= hold_data;
            if (i_vita_time > hold_data) begin
              o_tx_late <= 1'b1;
              state     <= chdr_pkg::TX_PLAY;
            end else begin
              state <= chdr_pkg::TX_WAIT;
            end
          end
        end
        default: begin
          if (play_now) begin
            o_tx_sample <= half_sel ? hold_data[31:0] : hold_data[63:32];
            half_sel    <= !half_sel;
            burst_open  <= 1'b1;
            state       <= chdr_pkg::TX_PLAY;
            if (half_sel && hold_last) begin
              state      <= chdr_pkg::TX_HDR;
              burst_open <= !pkt_eob;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== source/radio_block.sv ====
//////////////////////////////
// Radio block top: control, timekeeper, RX framer, TX deframer
//////////////////////////////

module radio_block #(
  parameter int SPP = 8
) (
  input  logic        ce_clk,
  input  logic        i_rst,
  // Settings and readback
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic        i_rb_stb,
  input  logic [7:0]  i_rb_addr,
  output logic        o_rb_stb,
  output logic [63:0] o_rb_data,
  // Radio front end
  input  logic        i_pps,
  input  logic [31:0] i_rx_sample,
  input  logic        i_rx_stb,
  input  logic        i_tx_stb,
  output logic [31:0] o_tx_sample,
  // Sample streams
  output logic [63:0] o_rx_tdata,
  output logic        o_rx_tlast,
  output logic        o_rx_tvalid,
  input  logic        i_rx_tready,
  input  logic [63:0] i_tx_tdata,
  input  logic        i_tx_tlast,
  input  logic        i_tx_tvalid,
  output logic        o_tx_tready
);

  logic [63:0] vita_time, vita_lastpps, time_value;
  logic load_now, load_pps;
  logic rx_enable, rx_last, rx_overflow;
  logic tx_underflow, tx_late;

  radio_ctrl radio_ctrl (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rb_stb(i_rb_stb), .i_rb_addr(i_rb_addr), .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data),
    .i_vita_time(vita_time), .i_vita_lastpps(vita_lastpps),
    .i_rx_stb(i_rx_stb), .o_rx_enable(rx_enable), .o_rx_last(rx_last),
    .i_rx_overflow(rx_overflow), .i_tx_underflow(tx_underflow), .i_tx_late(tx_late),
    .o_time_value(time_value), .o_load_now(load_now), .o_load_pps(load_pps));

  timekeeper timekeeper (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_pps(i_pps), .i_rx_stb(i_rx_stb),
    .i_time_value(time_value), .i_load_now(load_now), .i_load_pps(load_pps),
    .o_vita_time(vita_time), .o_vita_lastpps(vita_lastpps));

  rx_framer #(
    .SPP(SPP))
  rx_framer (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_rx_sample(i_rx_sample), .i_rx_stb(i_rx_stb),
    .i_rx_enable(rx_enable), .i_rx_last(rx_last), .i_vita_time(vita_time),
    .o_rx_tdata(o_rx_tdata), .o_rx_tlast(o_rx_tlast),
    .o_rx_tvalid(o_rx_tvalid), .i_rx_tready(i_rx_tready),
    .o_rx_overflow(rx_overflow));

  tx_deframer tx_deframer (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_tx_tdata(i_tx_tdata), .i_tx_tlast(i_tx_tlast),
    .i_tx_tvalid(i_tx_tvalid), .o_tx_tready(o_tx_tready),
    .i_tx_stb(i_tx_stb), .i_vita_time(vita_time), .o_tx_sample(o_tx_sample),
    .o_tx_underflow(tx_underflow), .o_tx_late(tx_late));

endmodule

// ==== include/radio_ref.svh ====
//////////////////////////////
// Sample LFSR and expected packet word builders
//////////////////////////////

`ifndef RADIO_REF_SVH
`define RADIO_REF_SVH

localparam logic [31:0] LFSR_SEED = 32'd83646;

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One step per bit taken
function automatic logic [31:0] lfsr_take(inout logic [31:0] s, input int unsigned nbits);
  logic [31:0] v;
  v = '0;
  for (int unsigned i = 0; i < nbits; i++) begin
    s = lfsr_step(s);
    v = {v[30:0], s[0]};
  end
  return v;
endfunction

// Type, has-time, EOB, sequence and byte length from bit 63 down
function automatic logic [63:0] ref_header(input logic [11:0] seq, input logic eob,
                                           input int unsigned nsamps);
  int unsigned nwords;
  // Header and time word, then one word per sample pair
  nwords = 2 + nsamps / 2 + nsamps % 2;
  return {2'(chdr_pkg::PKT_DATA), 1'b1, eob, seq, 16'(nwords * 8), 32'd0};
endfunction

// Earlier sample in the high half
function automatic logic [63:0] ref_payload(input logic [31:0] s0, input logic [31:0] s1,
                                            input logic has_s1);
  return {s0, has_s1 ? s1 : 32'd0};
endfunction

`endif

// ==== tb/tb_radio_block.sv ====
//////////////////////////////
// Radio block testbench covering time load, PPS load, RX framing,
// RX overflow, timed and late TX playout
//////////////////////////////

module tb_radio_block;

  localparam int SPP       = 8;
  localparam int STB_CYC   = 4;
  localparam int K_STB     = 5;
  localparam int PRE_STB   = 3;
  localparam int M_STB     = 4;
  localparam int BURST     = 20;
  localparam int N_OVF     = 21;
  localparam int TX5_SAMPS = 6;
  localparam int TX5_STB   = 19;
  localparam int TX6_SAMPS = 4;
  localparam int TX6_STB   = 7;
  // Twice the strobe time of all tests plus setup and readback overhead
  localparam int LIMIT = 2 * (STB_CYC * (K_STB + PRE_STB + M_STB + BURST + N_OVF
                         + TX5_STB + TX6_STB) + 6 * 60);

  logic        ce_clk;
  logic        i_rst;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic        i_rb_stb;
  logic [7:0]  i_rb_addr;
  logic        o_rb_stb;
  logic [63:0] o_rb_data;
  logic        i_pps;
  logic [31:0] i_rx_sample;
  logic        i_rx_stb;
  logic        i_tx_stb;
  logic [31:0] o_tx_sample;
  logic [63:0] o_rx_tdata;
  logic        o_rx_tlast;
  logic        o_rx_tvalid;
  logic        i_rx_tready;
  logic [63:0] i_tx_tdata;
  logic        i_tx_tlast;
  logic        i_tx_tvalid;
  logic        o_tx_tready;

  `include "radio_ref.svh"

  logic [31:0] lfsr_state;
  logic [63:0] model_time;
  logic [11:0] rx_seq;
  int model_ovf, model_udf, model_late;
  int errors, tests_pass, tests_fail, cycle_cnt, tx_sent;
  logic [64:0] rx_exp [$];
  logic [31:0] rx_samp [$];
  logic [31:0] tx_samp [$];
  logic [63:0] tx_words [$];

  radio_block #(
    .SPP(SPP))
  dut (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_rb_stb(i_rb_stb), .i_rb_addr(i_rb_addr), .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data),
    .i_pps(i_pps), .i_rx_sample(i_rx_sample), .i_rx_stb(i_rx_stb),
    .i_tx_stb(i_tx_stb), .o_tx_sample(o_tx_sample),
    .o_rx_tdata(o_rx_tdata), .o_rx_tlast(o_rx_tlast),
    .o_rx_tvalid(o_rx_tvalid), .i_rx_tready(i_rx_tready),
    .i_tx_tdata(i_tx_tdata), .i_tx_tlast(i_tx_tlast),
    .i_tx_tvalid(i_tx_tvalid), .o_tx_tready(o_tx_tready));

  always #10 ce_clk = ~ce_clk;

  always @(posedge ce_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout after %0d cycles, a test did not complete", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////
  // RX stream comparison
  //////////////////////////////
  always @(posedge ce_clk) begin
    logic [64:0] e;
    if (!i_rst && o_rx_tvalid && i_rx_tready) begin
      if (rx_exp.size() == 0) begin
        errors = errors + 1;
        $display("Unexpected RX word %h with no packet pending", o_rx_tdata);
      end else begin
        e = rx_exp.pop_front();
        if (o_rx_tdata !== e[63:0]) begin
          errors = errors + 1;
          $display("MISMATCH o_rx_tdata: got %h expected %h", o_rx_tdata, e[63:0]);
        end
        if (o_rx_tlast !== e[64]) begin
          errors = errors + 1;
          $display("MISMATCH o_rx_tlast: got %h expected %h", o_rx_tlast, e[64]);
        end
      end
    end
  end

  // Expected TX output for the strobe idx steps after playout start
  function automatic logic [31:0] tx_expected(input longint idx);
    if (idx < 0 || idx >= longint'(tx_samp.size())) return 32'd0;
    return tx_samp[idx];
  endfunction

  task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge ce_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb = 1'b0;
  endtask

  task automatic readback_check(input logic [7:0] addr, input logic [63:0] exp,
                                input string what);
    @(negedge ce_clk);
    i_rb_stb  = 1'b1;
    i_rb_addr = addr;
    @(negedge ce_clk);
    i_rb_stb = 1'b0;
    // Response is due exactly one cycle after the request
    if (o_rb_stb !== 1'b1) begin
      errors = errors + 1;
      $display("Readback of %s did not return its strobe one cycle later", what);
    end else if (o_rb_data !== exp) begin
      errors = errors + 1;
      $display("MISMATCH o_rb_data (%s): got %h expected %h", what, o_rb_data, exp);
    end
    @(negedge ce_clk);
    if (o_rb_stb !== 1'b0) begin
      errors = errors + 1;
      $display("Readback strobe for %s stayed high longer than one cycle", what);
    end
  endtask

  // One radio strobe per STB_CYC cycles
  task automatic strobe(input logic [31:0] sample, input logic tx_on);
    @(negedge ce_clk);
    i_rx_stb    = 1'b1;
    i_tx_stb    = tx_on;
    i_rx_sample = sample;
    @(negedge ce_clk);
    i_rx_stb   = 1'b0;
    i_tx_stb   = 1'b0;
    model_time = model_time + 64'd1;
    repeat (STB_CYC - 2) @(negedge ce_clk);
  endtask

  task automatic check_tx(input logic [31:0] exp);
    if (o_tx_sample !== exp) begin
      errors = errors + 1;
      $display("MISMATCH o_tx_sample: got %h expected %h", o_tx_sample, exp);
    end
  endtask

  task automatic push_packet(input int first, input int n, input logic eob,
                             input logic [63:0] t_first);
    int nw;
    logic has;
    logic [31:0] s1;
    nw = (n + 1) / 2;
    rx_exp.push_back({1'b0, ref_header(rx_seq, eob, n)});
    rx_exp.push_back({1'b0, t_first});
    for (int w = 0; w < nw; w++) begin
      has = (2 * w + 1 < n);
      s1  = has ? rx_samp[first + 2 * w + 1] : 32'd0;
      rx_exp.push_back({w == nw - 1, ref_payload(rx_samp[first + 2 * w], s1, has)});
    end
    rx_seq = rx_seq + 12'd1;
  endtask

  task automatic wait_rx_drain();
    while (rx_exp.size() != 0) @(negedge ce_clk);
    repeat (4) @(negedge ce_clk);
  endtask

  task automatic build_tx_packet(input logic [11:0] seq, input logic eob,
                                 input logic [63:0] tp, input int n);
    tx_samp.delete();
    tx_words.delete();
    for (int i = 0; i < n; i++) tx_samp.push_back(lfsr_take(lfsr_state, 32));
    tx_words.push_back(ref_header(seq, eob, n));
    tx_words.push_back(tp);
    for (int w = 0; w < n / 2; w++)
      tx_words.push_back(ref_payload(tx_samp[2 * w], tx_samp[2 * w + 1], 1'b1));
  endtask

  task automatic send_words();
    tx_sent = 0;
    for (int i = 0; i < tx_words.size(); i++) begin
      @(negedge ce_clk);
      i_tx_tvalid = 1'b1;
      i_tx_tdata  = tx_words[i];
      i_tx_tlast  = (i == tx_words.size() - 1);
      @(posedge ce_clk);
      while (!o_tx_tready) @(posedge ce_clk);
      tx_sent++;
    end
    @(negedge ce_clk);
    i_tx_tvalid = 1'b0;
    i_tx_tlast  = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_pass++;
      $display("[ok]   %s", name);
    end else begin
      tests_fail++;
      $display("[FAIL] %s, %0d errors", name, errors - errs_before);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic test_time_now();
    logic [63:0] v;
    v = 64'h0000_0042_1000_0000;
    set_write(radio_regs_pkg::SR_TIME_HI, v[63:32]);
    set_write(radio_regs_pkg::SR_TIME_LO, v[31:0]);
    set_write(radio_regs_pkg::SR_TIME_CTRL, 32'd1);
    model_time = v;
    repeat (K_STB) strobe(32'd0, 1'b0);
    readback_check(radio_regs_pkg::RB_VITA_TIME, model_time, "RB_VITA_TIME");
  endtask

  task automatic test_pps_load();
    logic [63:0] v;
    v = 64'h0000_0007_ffff_fffe;
    set_write(radio_regs_pkg::SR_TIME_HI, v[63:32]);
    set_write(radio_regs_pkg::SR_TIME_LO, v[31:0]);
    set_write(radio_regs_pkg::SR_TIME_CTRL, 32'd2);
    repeat (PRE_STB) strobe(32'd0, 1'b0);
    @(negedge ce_clk);
    i_pps = 1'b1;
    repeat (2) @(negedge ce_clk);
    i_pps = 1'b0;
    @(negedge ce_clk);
    model_time = v;
    repeat (M_STB) strobe(32'd0, 1'b0);
    readback_check(radio_regs_pkg::RB_VITA_LASTPPS, v, "RB_VITA_LASTPPS");
    readback_check(radio_regs_pkg::RB_VITA_TIME, model_time, "RB_VITA_TIME");
  endtask

  task automatic test_rx_burst();
    logic [63:0] t0;
    int first;
    int n;
    rx_samp.delete();
    for (int i = 0; i < BURST; i++) rx_samp.push_back(lfsr_take(lfsr_state, 32));
    t0 = model_time;
    first = 0;
    while (first < BURST) begin
      n = (BURST - first < SPP) ? BURST - first : SPP;
      push_packet(first, n, first + n == BURST, t0 + 64'(first));
      first += n;
    end
    set_write(radio_regs_pkg::SR_RX_CMD, {2'(radio_regs_pkg::RX_NUM_SAMPS), 6'd0, 24'(BURST)});
    for (int i = 0; i < BURST; i++) strobe(rx_samp[i], 1'b0);
    wait_rx_drain();
  endtask

  task automatic test_rx_overflow();
    logic [63:0] t0;
    rx_samp.delete();
    for (int i = 0; i < N_OVF; i++) rx_samp.push_back(lfsr_take(lfsr_state, 32));
    t0 = model_time;
    // Only the two buffered packets survive
    push_packet(0, SPP, 1'b0, t0);
    push_packet(SPP, SPP, 1'b0, t0 + 64'(SPP));
    model_ovf += N_OVF - 2 * SPP;
    @(negedge ce_clk);
    i_rx_tready = 1'b0;
    set_write(radio_regs_pkg::SR_RX_CMD, {2'(radio_regs_pkg::RX_CONT), 30'd0});
    for (int i = 0; i < N_OVF; i++) strobe(rx_samp[i], 1'b0);
    set_write(radio_regs_pkg::SR_RX_CMD, {2'(radio_regs_pkg::RX_STOP), 30'd0});
    readback_check(radio_regs_pkg::RB_RX_OVERFLOWS, 64'(model_ovf), "RB_RX_OVERFLOWS");
    @(negedge ce_clk);
    i_rx_tready = 1'b1;
    wait_rx_drain();
  endtask

  task automatic test_tx_timed();
    logic [63:0] tp;
    tp = model_time + 64'd10;
    build_tx_packet(12'd0, 1'b1, tp, TX5_SAMPS);
    fork
      send_words();
      begin
        logic [63:0] t_now;
        for (int k = 0; k < TX5_STB; k++) begin
          t_now = model_time;
          strobe(32'd0, 1'b1);
          check_tx(tx_expected(longint'($signed(t_now - tp))));
        end
      end
    join
    readback_check(radio_regs_pkg::RB_TX_UNDERFLOWS, 64'(model_udf), "RB_TX_UNDERFLOWS");
    readback_check(radio_regs_pkg::RB_TX_LATE, 64'(model_late), "RB_TX_LATE");
  endtask

  task automatic test_tx_late();
    build_tx_packet(12'd1, 1'b0, model_time - 64'd5, TX6_SAMPS);
    model_late += 1;
    model_udf  += TX6_STB - TX6_SAMPS;
    tx_sent = 0;
    fork
      send_words();
      begin
        // First payload word accepted means the time word is parsed
        wait (tx_sent >= 3);
        for (int k = 0; k < TX6_STB; k++) begin
          strobe(32'd0, 1'b1);
          check_tx(tx_expected(longint'(k)));
        end
      end
    join
    readback_check(radio_regs_pkg::RB_TX_LATE, 64'(model_late), "RB_TX_LATE");
    readback_check(radio_regs_pkg::RB_TX_UNDERFLOWS, 64'(model_udf), "RB_TX_UNDERFLOWS");
  endtask

  initial begin
    int e0;
    ce_clk      = 1'b0;
    i_rst       = 1'b1;
    i_set_stb   = 1'b0;
    i_set_addr  = '0;
    i_set_data  = '0;
    i_rb_stb    = 1'b0;
    i_rb_addr   = '0;
    i_pps       = 1'b0;
    i_rx_sample = '0;
    i_rx_stb    = 1'b0;
    i_tx_stb    = 1'b0;
    i_rx_tready = 1'b1;
    i_tx_tdata  = '0;
    i_tx_tlast  = 1'b0;
    i_tx_tvalid = 1'b0;
    lfsr_state  = LFSR_SEED;
    model_time  = '0;
    rx_seq      = '0;
    model_ovf   = 0;
    model_udf   = 0;
    model_late  = 0;
    errors      = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    cycle_cnt   = 0;
    tx_sent     = 0;
    repeat (4) @(negedge ce_clk);
    i_rst = 1'b0;

    e0 = errors;
    test_time_now();
    finish_test("time load now", e0);
    e0 = errors;
    test_pps_load();
    finish_test("time load at PPS", e0);
    e0 = errors;
    test_rx_burst();
    finish_test("counted RX burst", e0);
    e0 = errors;
    test_rx_overflow();
    finish_test("RX overflow under back-pressure", e0);
    e0 = errors;
    test_tx_timed();
    finish_test("timed TX burst", e0);
    e0 = errors;
    test_tx_late();
    finish_test("late TX packet and underflow", e0);

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
source/radio_regs_pkg.sv
source/chdr_pkg.sv
source/radio_ctrl.sv
source/timekeeper.sv
source/rx_framer.sv
source/tx_deframer.sv
source/radio_block.sv
tb/tb_radio_block.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary -Wno-fatal
TOP      = tb_radio_block
FILELIST = sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
